//--- sd_spi.f
verilog/sd_bus_pkg.sv
verilog/sd_proto_pkg.sv
verilog/sd_sck_gen.sv
verilog/sd_block_fifo.sv
verilog/sd_xfer_engine.sv
verilog/sd_reg_block.sv
verilog/sd_spi_top.sv
bench/sd_card_model.sv
bench/sd_spi_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= sd_spi_tb
SEED      ?= 1
BUILD_DIR ?= obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) --binary --timing --assert --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -f sd_spi.f
	./$(BUILD_DIR)/V$(TOP) +verilator+seed+$(SEED) | tee /dev/stderr | \
		grep -q "RESULT: PASS"

clean:
	rm -rf $(BUILD_DIR)

//--- bench/sd_spi_tb.sv
`timescale 1ns/10ps
`default_nettype none

module sd_spi_tb;

  localparam int CMD_LIMIT = 100000;

  logic                 clk;
  logic                 rst;
  sd_bus_pkg::bus_req_t bus;
  logic                 bus_ack;
  logic [31:0]          bus_rdata;
  logic                 spi_req;
  logic                 spi_ack;
  logic                 spi_done;
  logic                 sck;
  logic                 cs_n;
  logic                 mosi;
  logic                 miso;
  logic [47:0]          card_frame;
  logic [31:0]          rd;
  int                   errors;
  int                   tests;
  int                   failed_tests;
  int                   done_count = 0;
  int                   err_before;
  integer               seed;

  sd_spi_top #(
    .SCK_DIVIDE (6)
  ) u_dut (
    .clk         (clk),
    .rst         (rst),
    .i_bus       (bus),
    .o_bus_ack   (bus_ack),
    .o_bus_rdata (bus_rdata),
    .o_spi_req   (spi_req),
    .i_spi_ack   (spi_ack),
    .o_spi_done  (spi_done),
    .o_sck       (sck),
    .o_cs_n      (cs_n),
    .o_mosi      (mosi),
    .i_miso      (miso)
  );

  sd_card_model u_card (
    .i_sck   (sck),
    .i_cs_n  (cs_n),
    .i_mosi  (mosi),
    .o_miso  (miso),
    .o_frame (card_frame)
  );

  initial
  begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  always @(posedge spi_done)
    done_count <= done_count + 1;

  // Transfer end must release the held CMD_SEND access
  assert property (@(posedge clk) disable iff (rst) spi_done |-> bus_ack)
    else
    begin
      $display("MISMATCH at %0t: bus ack did not come with the done pulse", $time);
      errors++;
    end

  // Pins stay idle until the delayed grant
  initial
  begin : arbiter
    int delay;
    int n;
    forever
    begin
      @(posedge clk);
      #1;
      if (spi_req && !spi_ack)
      begin
        delay = $unsigned($random(seed)) % 8;
        repeat (delay)
        begin
          assert (spi_req && cs_n)
            else
            begin
              $display("MISMATCH at %0t: request dropped or CS_n low before grant", $time);
              errors++;
            end
          @(posedge clk);
          #1;
        end
        spi_ack = 1'b1;
        n = 0;
        while (spi_req && n < 100)
        begin
          @(posedge clk);
          #1;
          n++;
        end
        if (spi_req)
        begin
          $display("SPI request still high 100 cycles after the grant at %0t", $time);
          errors++;
        end
        spi_ack = 1'b0;
      end
    end
  end

  task automatic bus_access(input logic wr, input logic [29:0] addr, input logic [31:0] wdata,
                            input logic wr_en, input int limit, output logic [31:0] rdata);
    int n;
    bus.req   = 1'b1;
    bus.write = wr;
    bus.addr  = addr;
    bus.wdata = wdata;
    bus.wr_en = wr_en;
    rdata     = '0;
    n         = 0;
    do
    begin
      @(posedge clk);
      #1;
      n++;
    end
    while (!bus_ack && n < limit);
    if (bus_ack)
      rdata = bus_rdata;
    else
    begin
      $display("No bus ack for address %0d within %0d cycles", addr, limit);
      errors++;
    end
    bus.req = 1'b0;
  endtask

  task automatic check_eq(input string what, input logic [63:0] got, input logic [63:0] exp);
    assert (got === exp)
      else
      begin
        $display("MISMATCH at %0t: %s got %0h expected %0h", $time, what, got, exp);
        errors++;
      end
  endtask

  task automatic run_cmd(input logic [5:0] idx, input logic [31:0] arg,
                         input logic [6:0] rsp_bytes, input logic capture);
    logic [47:0] frame;
    logic [31:0] dummy;
    int          done_before;
    frame = {2'b01, idx, arg, 7'h00, 1'b1};
    done_before = done_count;
    bus_access(1'b1, sd_bus_pkg::CMD_LO, frame[31:0], 1'b1, 10, dummy);
    bus_access(1'b1, sd_bus_pkg::CMD_HI, {capture, rsp_bytes, 8'h00, frame[47:32]}, 1'b1, 10,
               dummy);
    bus_access(1'b1, sd_bus_pkg::CMD_SEND, 32'd0, 1'b1, CMD_LIMIT, dummy);
    check_eq("frame seen by card", 64'(card_frame), 64'(frame));
    check_eq("done pulses", 64'(done_count), 64'(done_before + 1));
  endtask

  function automatic logic [31:0] block_word(input int w);
    logic [31:0] v;
    int          n;
    v = '0;
    for (int k = 0; k < 4; k++)
    begin
      n = 4 * w + k;
      v = {v[23:0], 8'((n * 7 + 3) % 256)};
    end
    return v;
  endfunction

  task automatic end_test(input string name);
    tests++;
    if (errors == err_before)
      $display("test %0d %s: passed", tests, name);
    else
    begin
      failed_tests++;
      $display("test %0d %s: failed", tests, name);
    end
  endtask

  initial
  begin
    seed         = 32'h22b9f12d;
    errors       = 0;
    tests        = 0;
    failed_tests = 0;
    bus          = '0;
    spi_ack      = 1'b0;
    rst          = 1'b1;
    repeat (2) @(posedge clk);
    #1;
    rst = 1'b0;

    err_before = errors;
    bus_access(1'b1, sd_bus_pkg::CMD_LO, 32'h1234_5678, 1'b1, 10, rd);
    bus_access(1'b1, sd_bus_pkg::CMD_HI, 32'h8055_AAAA, 1'b1, 10, rd);
    bus_access(1'b1, sd_bus_pkg::CMD_LO, 32'hDEAD_BEEF, 1'b0, 10, rd);
    bus_access(1'b1, sd_bus_pkg::CMD_HI, 32'hCAFE_F00D, 1'b0, 10, rd);
    bus_access(1'b0, sd_bus_pkg::CMD_LO, 32'd0, 1'b0, 10, rd);
    check_eq("CMD_LO", 64'(rd), 64'h1234_5678);
    bus_access(1'b0, sd_bus_pkg::CMD_HI, 32'd0, 1'b0, 10, rd);
    check_eq("CMD_HI", 64'(rd), 64'h8055_AAAA);
    bus_access(1'b0, 30'd9, 32'hA5A5_5A5A, 1'b0, 10, rd);
    check_eq("unknown address", 64'(rd), 64'd0);
    end_test("register access");

    err_before = errors;
    run_cmd(6'd0, 32'd0, 7'd1, 1'b0);
    end_test("arbitration and frame");

    err_before = errors;
    run_cmd(6'd13, 32'h0000_5A5A, 7'd1, 1'b0);
    bus_access(1'b0, sd_bus_pkg::STATUS, 32'd0, 1'b0, 10, rd);
    check_eq("STATUS", 64'(rd), 64'h1);
    bus_access(1'b0, sd_bus_pkg::RSP_LO, 32'd0, 1'b0, 10, rd);
    check_eq("RSP_LO", 64'(rd), 64'd0);
    end_test("one byte response");

    err_before = errors;
    run_cmd(6'd8, 32'h0000_01AA, 7'd5, 1'b0);
    bus_access(1'b0, sd_bus_pkg::RSP_HI, 32'd0, 1'b0, 10, rd);
    check_eq("RSP_HI", 64'(rd), 64'h0001);
    bus_access(1'b0, sd_bus_pkg::RSP_LO, 32'd0, 1'b0, 10, rd);
    check_eq("RSP_LO", 64'(rd), 64'h0000_01AA);
    end_test("five byte response");

    err_before = errors;
    run_cmd(6'd17, 32'd0, 7'd1, 1'b1);
    bus_access(1'b0, sd_bus_pkg::STATUS, 32'd0, 1'b0, 10, rd);
    check_eq("STATUS", 64'(rd), 64'h3);
    for (int w = 0; w < 128; w++)
    begin
      bus_access(1'b0, sd_bus_pkg::DATA, 32'd0, 1'b0, 10, rd);
      check_eq($sformatf("DATA word %0d", w), 64'(rd), 64'(block_word(w)));
    end
    bus_access(1'b0, sd_bus_pkg::DATA, 32'd0, 1'b0, 10, rd);
    check_eq("DATA read when empty", 64'(rd), 64'd0);
    end_test("block read");

    err_before = errors;
    run_cmd(6'd18, 32'd0, 7'd1, 1'b1);
    bus_access(1'b0, sd_bus_pkg::STATUS, 32'd0, 1'b0, 10, rd);
    check_eq("STATUS", 64'(rd), 64'h5);
    end_test("token timeout");

    $display("tests %0d, failed %0d, errors %0d", tests, failed_tests, errors);
    if (errors == 0 && failed_tests == 0)
      $display("RESULT: PASS");
    else
      $display("RESULT: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

//--- bench/sd_card_model.sv
`timescale 1ns/10ps
`default_nettype none

module sd_card_model (
  input  logic        i_sck,
  input  logic        i_cs_n,
  input  logic        i_mosi,
  output logic        o_miso,
  output logic [47:0] o_frame
);

  logic        tx_q[$];
  logic [47:0] shreg;
  int          nbits;

  task automatic push_byte(input logic [7:0] b);
    for (int i = 7; i >= 0; i--)
      tx_q.push_back(b[i]);
  endtask

  task automatic push_ones(input int count);
    repeat (count) tx_q.push_back(1'b1);
  endtask

  // Response bytes, then the data block for a single block read
  task automatic answer(input logic [5:0] idx);
    push_ones(8);
    if (idx == 6'd8)
    begin
      push_byte(8'h01);
      push_byte(8'h00);
      push_byte(8'h00);
      push_byte(8'h01);
      push_byte(8'hAA);
    end
    else
      push_byte(8'h00);
    if (idx == 6'd17)
    begin
      push_ones(20);
      push_byte(8'hFE);
      for (int n = 0; n < 512; n++)
        push_byte(8'((n * 7 + 3) % 256));
      push_byte(8'hC3);
      push_byte(8'h5A);
    end
  endtask

  // Host bits sampled on the rising SCK edge
  initial
  begin
    o_frame = '0;
    shreg   = '0;
    nbits   = 0;
    forever
    begin
      @(posedge i_sck);
      if (i_cs_n)
        nbits = 0;
      // A frame starts with a zero bit
      else if (nbits != 0 || !i_mosi)
      begin
        shreg = {shreg[46:0], i_mosi};
        nbits++;
        if (nbits == 48)
        begin
          o_frame = shreg;
          nbits   = 0;
          answer(shreg[45:40]);
        end
      end
    end
  end

  // Card output changes on the falling SCK edge
  initial
  begin
    o_miso = 1'b1;
    forever
    begin
      @(negedge i_sck);
      if (tx_q.size() > 0)
        o_miso = tx_q.pop_front();
      else
        o_miso = 1'b1;
    end
  end

endmodule

`default_nettype wire

//--- verilog/sd_spi_top.sv
`timescale 1ns/10ps
`default_nettype none

module sd_spi_top #(
  parameter int SCK_DIVIDE = 6,
  parameter int FIFO_WORDS = sd_proto_pkg::BLOCK_WORDS
) (
  input  logic                 clk,
  input  logic                 rst,
  input  sd_bus_pkg::bus_req_t i_bus,
  output logic                 o_bus_ack,
  output logic [31:0]          o_bus_rdata,
  output logic                 o_spi_req,
  input  logic                 i_spi_ack,
  output logic                 o_spi_done,
  output logic                 o_sck,
  output logic                 o_cs_n,
  output logic                 o_mosi,
  input  logic                 i_miso
);

  logic                                  start;
  sd_proto_pkg::cmd_t                    cmd;
  logic                                  done;
  logic [sd_proto_pkg::RSP_MAX_BITS-1:0] rsp;
  sd_bus_pkg::status_t                   status;
  logic                                  status_valid;
  logic                                  bit_strobe;
  logic                                  fifo_clr;
  logic                                  fifo_bit_valid;
  logic                                  fifo_bit;
  logic                                  pop;
  logic [31:0]                           fifo_word;
  logic                                  fifo_empty;

  sd_reg_block u_regs (
    .clk            (clk),
    .rst            (rst),
    .i_bus          (i_bus),
    .o_bus_ack      (o_bus_ack),
    .o_bus_rdata    (o_bus_rdata),
    .o_start        (start),
    .o_cmd          (cmd),
    .i_done         (done),
    .i_rsp          (rsp),
    .i_status       (status),
    .i_status_valid (status_valid),
    .o_pop          (pop),
    .i_fifo_word    (fifo_word),
    .i_fifo_empty   (fifo_empty)
  );

  sd_sck_gen #(
    .SCK_DIVIDE (SCK_DIVIDE)
  ) u_sck (
    .clk          (clk),
    .rst          (rst),
    .o_sck        (o_sck),
    .o_bit_strobe (bit_strobe)
  );

  sd_xfer_engine u_engine (
    .clk              (clk),
    .rst              (rst),
    .i_start          (start),
    .i_cmd            (cmd),
    .i_bit_strobe     (bit_strobe),
    .o_spi_req        (o_spi_req),
    .i_spi_ack        (i_spi_ack),
    .o_spi_done       (o_spi_done),
    .o_cs_n           (o_cs_n),
    .o_mosi           (o_mosi),
    .i_miso           (i_miso),
    .o_done           (done),
    .o_rsp            (rsp),
    .o_status         (status),
    .o_status_valid   (status_valid),
    .o_fifo_clr       (fifo_clr),
    .o_fifo_bit_valid (fifo_bit_valid),
    .o_fifo_bit       (fifo_bit)
  );

  sd_block_fifo #(
    .FIFO_WORDS (FIFO_WORDS)
  ) u_fifo (
    .clk         (clk),
    .rst         (rst),
    .i_clr       (fifo_clr),
    .i_bit_valid (fifo_bit_valid),
    .i_bit       (fifo_bit),
    .i_pop       (pop),
    .o_word      (fifo_word),
    .o_empty     (fifo_empty)
  );

endmodule

`default_nettype wire

//--- verilog/sd_reg_block.sv
`timescale 1ns/10ps
`default_nettype none

module sd_reg_block (
  input  logic                                  clk,
  input  logic                                  rst,
  input  sd_bus_pkg::bus_req_t                  i_bus,
  output logic                                  o_bus_ack,
  output logic [31:0]                           o_bus_rdata,
  output logic                                  o_start,
  output sd_proto_pkg::cmd_t                    o_cmd,
  input  logic                                  i_done,
  input  logic [sd_proto_pkg::RSP_MAX_BITS-1:0] i_rsp,
  input  sd_bus_pkg::status_t                   i_status,
  input  logic                                  i_status_valid,
  output logic                                  o_pop,
  input  logic [31:0]                           i_fifo_word,
  input  logic                                  i_fifo_empty
);

  logic                busy;
  logic                ack_q;
  logic                cmd_wr;
  sd_proto_pkg::cmd_t  cmd;
  sd_bus_pkg::status_t status;

  assign o_cmd  = cmd;
  assign cmd_wr = i_bus.write && i_bus.wr_en;

  // Held CMD_SEND access is released with the done pulse
  assign o_bus_ack = ack_q || (busy && i_done);

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      busy        <= 1'b0;
      ack_q       <= 1'b0;
      cmd         <= '0;
      status      <= '0;
      o_bus_rdata <= '0;
      o_start     <= 1'b0;
      o_pop       <= 1'b0;
    end
    else
    begin
      ack_q       <= 1'b0;
      o_bus_rdata <= '0;
      o_start     <= 1'b0;
      o_pop       <= 1'b0;

      // Flags stay set until the next command
      if (i_status_valid)
        status <= status | i_status;

      if (busy)
      begin
        if (i_done)
          busy <= 1'b0;
      end
      else if (i_bus.req && !ack_q)
      begin
        ack_q <= 1'b1;
        case (i_bus.addr)
          sd_bus_pkg::NOOP:
            o_bus_rdata <= '0;
          sd_bus_pkg::CMD_SEND:
          begin
            // Ack held back until the transfer ends
            if (i_bus.write)
            begin
              ack_q   <= 1'b0;
              o_start <= 1'b1;
              busy    <= 1'b1;
              status  <= '0;
            end
          end
          sd_bus_pkg::CMD_LO:
          begin
            if (cmd_wr)
              cmd[31:0] <= i_bus.wdata;
            o_bus_rdata <= cmd[31:0];
          end
          sd_bus_pkg::CMD_HI:
          begin
            if (cmd_wr)
              cmd[63:32] <= i_bus.wdata;
            o_bus_rdata <= cmd[63:32];
          end
          sd_bus_pkg::STATUS:
            o_bus_rdata <= {29'd0, status};
          sd_bus_pkg::RSP_LO:
            o_bus_rdata <= i_rsp[31:0];
          sd_bus_pkg::RSP_HI:
            o_bus_rdata <= {16'd0, i_rsp[47:32]};
          sd_bus_pkg::DATA:
          begin
            if (!i_bus.write)
            begin
              o_pop       <= 1'b1;
              o_bus_rdata <= i_fifo_empty ? 32'd0 : i_fifo_word;
            end
          end
          default:
            o_bus_rdata <= '0;
        endcase
      end
    end
  end

  // One pulse per access
  assert property (@(posedge clk) disable iff (rst) o_bus_ack |=> !o_bus_ack);

endmodule

`default_nettype wire

//--- verilog/sd_xfer_engine.sv
`timescale 1ns/10ps
`default_nettype none

module sd_xfer_engine (
  input  logic                                  clk,
  input  logic                                  rst,
  input  logic                                  i_start,
  input  sd_proto_pkg::cmd_t                    i_cmd,
  input  logic                                  i_bit_strobe,
  output logic                                  o_spi_req,
  input  logic                                  i_spi_ack,
  output logic                                  o_spi_done,
  output logic                                  o_cs_n,
  output logic                                  o_mosi,
  input  logic                                  i_miso,
  output logic                                  o_done,
  output logic [sd_proto_pkg::RSP_MAX_BITS-1:0] o_rsp,
  output sd_bus_pkg::status_t                   o_status,
  output logic                                  o_status_valid,
  output logic                                  o_fifo_clr,
  output logic                                  o_fifo_bit_valid,
  output logic                                  o_fifo_bit
);

  localparam logic [12:0] FRAME_LAST = 13'(sd_proto_pkg::FRAME_BITS - 1);
  localparam logic [12:0] DATA_BITS  = 13'(sd_proto_pkg::BLOCK_BYTES * 8);
  localparam logic [12:0] BLOCK_LAST =
    13'(sd_proto_pkg::BLOCK_BYTES * 8 + sd_proto_pkg::CRC_BITS - 1);
  localparam logic [8:0]  TOKEN_LAST = 9'(sd_proto_pkg::TOKEN_TIMEOUT);

  sd_proto_pkg::xfer_state_e state;
  logic [12:0]               bit_cnt;
  logic [9:0]                rsp_bits;
  logic [7:0]                token_sr;
  logic [7:0]                token_next;
  logic [8:0]                token_wait;

  assign rsp_bits   = {i_cmd.rsp_bytes, 3'b000};
  assign token_next = {token_sr[6:0], i_miso};
  assign o_done     = o_spi_done;

  // CRC trailer is clocked in but never stored
  assign o_fifo_bit_valid = (state == sd_proto_pkg::BLOCK_SHIFT) && i_bit_strobe &&
                            (bit_cnt < DATA_BITS);
  assign o_fifo_bit       = i_miso;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state          <= sd_proto_pkg::IDLE;
      bit_cnt        <= '0;
      token_sr       <= '0;
      token_wait     <= '0;
      o_spi_req      <= 1'b0;
      o_spi_done     <= 1'b0;
      o_cs_n         <= 1'b1;
      o_mosi         <= 1'b1;
      o_rsp          <= '0;
      o_status       <= '0;
      o_status_valid <= 1'b0;
      o_fifo_clr     <= 1'b0;
    end
    else
    begin
      o_spi_done     <= 1'b0;
      o_status_valid <= 1'b0;
      o_fifo_clr     <= 1'b0;
      case (state)
        sd_proto_pkg::IDLE:
          if (i_start)
          begin
            o_spi_req <= 1'b1;
            o_rsp     <= '0;
            state     <= sd_proto_pkg::ARB_WAIT;
          end
        sd_proto_pkg::ARB_WAIT:
          if (i_spi_ack)
          begin
            o_spi_req <= 1'b0;
            bit_cnt   <= FRAME_LAST;
            state     <= sd_proto_pkg::CMD_SHIFT;
          end
        sd_proto_pkg::CMD_SHIFT:
          if (i_bit_strobe)
          begin
            o_cs_n <= 1'b0;
            o_mosi <= i_cmd.frame[bit_cnt[5:0]];
            if (bit_cnt == '0)
              state <= sd_proto_pkg::RSP_WAIT;
            else
              bit_cnt <= bit_cnt - 1'b1;
          end
        sd_proto_pkg::RSP_WAIT:
          if (i_bit_strobe)
          begin
            o_mosi <= 1'b1;
            // Start bit counts as the first response bit
            if (!i_miso)
            begin
              bit_cnt <= 13'd1;
              state   <= sd_proto_pkg::RSP_SHIFT;
            end
          end
        sd_proto_pkg::RSP_SHIFT:
          if (i_bit_strobe)
          begin
            o_rsp <= {o_rsp[46:0], i_miso};
            if (bit_cnt == {3'b000, rsp_bits} - 13'd1)
            begin
              o_status       <= '{rsp_arrived: 1'b1, default: 1'b0};
              o_status_valid <= 1'b1;
              if (i_cmd.data_capture)
              begin
                token_sr   <= '0;
                token_wait <= '0;
                state      <= sd_proto_pkg::TOKEN_WAIT;
              end
              else
              begin
                o_cs_n     <= 1'b1;
                o_spi_done <= 1'b1;
                state      <= sd_proto_pkg::IDLE;
              end
            end
            else
              bit_cnt <= bit_cnt + 1'b1;
          end
        sd_proto_pkg::TOKEN_WAIT:
          if (i_bit_strobe)
          begin
            token_sr <= token_next;
            if (token_next == sd_proto_pkg::START_TOKEN)
            begin
              o_fifo_clr <= 1'b1;
              bit_cnt    <= '0;
              state      <= sd_proto_pkg::BLOCK_SHIFT;
            end
            else if (token_wait == TOKEN_LAST)
            begin
              // Card stays selected after a timeout
              o_status       <= '{data_timeout: 1'b1, default: 1'b0};
              o_status_valid <= 1'b1;
              o_spi_done     <= 1'b1;
              state          <= sd_proto_pkg::IDLE;
            end
            else
              token_wait <= token_wait + 1'b1;
          end
        sd_proto_pkg::BLOCK_SHIFT:
          if (i_bit_strobe)
          begin
            if (bit_cnt == BLOCK_LAST)
            begin
              o_cs_n         <= 1'b1;
              o_status       <= '{data_arrived: 1'b1, default: 1'b0};
              o_status_valid <= 1'b1;
              o_spi_done     <= 1'b1;
              state          <= sd_proto_pkg::IDLE;
            end
            else
              bit_cnt <= bit_cnt + 1'b1;
          end
        default:
          state <= sd_proto_pkg::IDLE;
      endcase
    end
  end

  // Selected while idle only when a token search just timed out
  assert property (@(posedge clk) disable iff (rst)
    (state inside {sd_proto_pkg::IDLE, sd_proto_pkg::ARB_WAIT}) && !o_cs_n |->
      $past(!o_cs_n) &&
      ($past(state) inside {sd_proto_pkg::IDLE, sd_proto_pkg::ARB_WAIT,
                            sd_proto_pkg::TOKEN_WAIT}));

endmodule

`default_nettype wire

//--- verilog/sd_block_fifo.sv
`timescale 1ns/10ps
`default_nettype none

module sd_block_fifo #(
  parameter int FIFO_WORDS = sd_proto_pkg::BLOCK_WORDS
) (
  input  logic        clk,
  input  logic        rst,
  input  logic        i_clr,
  input  logic        i_bit_valid,
  input  logic        i_bit,
  input  logic        i_pop,
  output logic [31:0] o_word,
  output logic        o_empty
);

  localparam int AW = $clog2(FIFO_WORDS);

  logic [31:0] mem [FIFO_WORDS];
  logic [30:0] shreg;
  logic [4:0]  bit_cnt;
  logic [AW:0] wr_ptr;
  logic [AW:0] rd_ptr;
  logic        push;
  logic        full;

  // First byte of each group lands in bits 31:24
  assign push    = i_bit_valid && (bit_cnt == 5'd31);
  assign full    = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);
  assign o_empty = (wr_ptr == rd_ptr);
  assign o_word  = mem[rd_ptr[AW-1:0]];

  always_ff @(posedge clk)
  begin
    if (i_bit_valid)
      shreg <= {shreg[29:0], i_bit};
    if (push)
      mem[wr_ptr[AW-1:0]] <= {shreg, i_bit};
  end

  always_ff @(posedge clk)
  begin
    if (rst || i_clr)
    begin
      bit_cnt <= '0;
      wr_ptr  <= '0;
      rd_ptr  <= '0;
    end
    else
    begin
      if (i_bit_valid)
        bit_cnt <= bit_cnt + 1'b1;
      if (push)
        wr_ptr <= wr_ptr + 1'b1;
      if (i_pop && !o_empty)
        rd_ptr <= rd_ptr + 1'b1;
    end
  end

  // Engine never delivers more than one block between clears
  assert property (@(posedge clk) disable iff (rst) push |-> !full);

endmodule

`default_nettype wire

//--- verilog/sd_sck_gen.sv
`timescale 1ns/10ps
`default_nettype none

module sd_sck_gen #(
  parameter int SCK_DIVIDE = 6
) (
  input  logic clk,
  input  logic rst,
  output logic o_sck,
  output logic o_bit_strobe
);

  localparam int CNT_W    = $clog2(SCK_DIVIDE + 1);
  localparam int HI_START = SCK_DIVIDE / 4;
  localparam int HI_END   = (SCK_DIVIDE * 3) / 4;

  logic [CNT_W-1:0] cnt;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      cnt          <= '0;
      o_sck        <= 1'b0;
      o_bit_strobe <= 1'b0;
    end
    else
    begin
      // High through the middle of the period
      o_sck        <= (cnt >= CNT_W'(HI_START)) && (cnt <= CNT_W'(HI_END));
      o_bit_strobe <= (cnt == CNT_W'(SCK_DIVIDE));
      if (cnt == CNT_W'(SCK_DIVIDE))
        cnt <= '0;
      else
        cnt <= cnt + 1'b1;
    end
  end

endmodule

`default_nettype wire

//--- verilog/sd_proto_pkg.sv
`default_nettype none

package sd_proto_pkg;

  localparam int FRAME_BITS    = 48;
  localparam int RSP_MAX_BITS  = 48;
  localparam int BLOCK_BYTES   = 512;
  localparam int BLOCK_WORDS   = 128;
  localparam int CRC_BITS      = 16;
  localparam int TOKEN_TIMEOUT = 511;

  localparam logic [7:0] START_TOKEN = 8'hFE;

  // Upper word is CMD_HI, lower word is CMD_LO
  typedef struct packed {
    logic        data_capture;
    logic [6:0]  rsp_bytes;
    logic [7:0]  pad;
    logic [47:0] frame;
  } cmd_t;

  typedef enum logic [2:0] {
    IDLE,
    ARB_WAIT,
    CMD_SHIFT,
    RSP_WAIT,
    RSP_SHIFT,
    TOKEN_WAIT,
    BLOCK_SHIFT
  } xfer_state_e;

endpackage

`default_nettype wire

//--- verilog/sd_bus_pkg.sv
`default_nettype none

package sd_bus_pkg;

  // Master holds every field steady until it sees the ack
  typedef struct packed {
    logic        req;
    logic        write;
    logic [29:0] addr;
    logic [31:0] wdata;
    logic        wr_en;
  } bus_req_t;

  typedef enum logic [29:0] {
    NOOP     = 30'd0,
    CMD_SEND = 30'd1,
    CMD_LO   = 30'd2,
    CMD_HI   = 30'd3,
    STATUS   = 30'd4,
    RSP_LO   = 30'd5,
    RSP_HI   = 30'd6,
    DATA     = 30'd7
  } reg_addr_e;

  // Bit 0 is rsp_arrived
  typedef struct packed {
    logic data_timeout;
    logic data_arrived;
    logic rsp_arrived;
  } status_t;

endpackage

`default_nettype wire
